// File: files.f
common/rv32v_types_pkg.sv
common/vtype_if.sv
decode/rv32v_opm_decode.sv
decode/rv32v_opi_decode.sv
src/rv32v_vtype_csr.sv
src/rv32v_decode_stage.sv
src/rv32v_decode_unit.sv
tests/rv32v_decode_checker.sv
tests/tb_rv32v_decode_unit.sv

// File: tests/tb_rv32v_decode_unit.sv
`timescale 1ns/100ps

module tb_rv32v_decode_unit;
    import rv32v_types_pkg::*;

    localparam int NUM_INSTR   = 2000;
    localparam int CYCLE_LIMIT = 3 * NUM_INSTR;     // about 2 cycles per instruction on average

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] avl;

    logic        out_valid;
    logic        illegal;
    vfu_t        vfu;
    valuop_t     valuop;
    vmulop_t     vmulop;
    logic        vmulwiden;
    logic        vmulrethigh;
    logic        vdivremainder;
    vmaskop_t    vmaskop;
    vsigntype_t  vsigntype;
    logic        vopunsigned;
    vsew_t       veew_src2;
    vsew_t       vsew;
    logic [31:0] vl;

    int          cycles = 0;
    int          gap;
    int          seed_ret;

    rv32v_decode_unit uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .avl           (avl),
        .out_valid     (out_valid),
        .illegal       (illegal),
        .vfu           (vfu),
        .valuop        (valuop),
        .vmulop        (vmulop),
        .vmulwiden     (vmulwiden),
        .vmulrethigh   (vmulrethigh),
        .vdivremainder (vdivremainder),
        .vmaskop       (vmaskop),
        .vsigntype     (vsigntype),
        .vopunsigned   (vopunsigned),
        .veew_src2     (veew_src2),
        .vsew          (vsew),
        .vl            (vl)
    );

    rv32v_decode_checker chk (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .avl           (avl),
        .out_valid     (out_valid),
        .illegal       (illegal),
        .vfu           (vfu),
        .valuop        (valuop),
        .vmulop        (vmulop),
        .vmulwiden     (vmulwiden),
        .vmulrethigh   (vmulrethigh),
        .vdivremainder (vdivremainder),
        .vmaskop       (vmaskop),
        .vsigntype     (vsigntype),
        .vopunsigned   (vopunsigned),
        .veew_src2     (veew_src2),
        .vsew          (vsew),
        .vl            (vl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // mostly supported encodings plus crossed categories and junk
    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        int          kind;
        int          sel;
        kind = $urandom_range(0, 99);
        sel  = $urandom_range(0, 2);
        w    = $urandom();
        w[6:0] = OPC_OPV;
        if (kind < 35) begin
            w[14:12] = (sel == 0) ? 3'd2 : 3'd6;    // OPMVV or OPMVX
            if ($urandom_range(0, 4) == 0) begin
                w[31:26] = 6'd18;                   // vzext / vsext
                w[19:15] = 5'($urandom_range(0, 8));
            end
        end else if (kind < 65) begin
            w[31:26] = 6'($urandom_range(0, 11));
            w[14:12] = (sel == 0) ? 3'd0 : (sel == 1) ? 3'd3 : 3'd4;
        end else if (kind < 85) begin
            w[31]    = 1'b0;                        // vsetvli
            w[30:26] = 5'd0;
            w[14:12] = 3'd7;
            w[25:23] = 3'($urandom_range(0, 3));
            if ($urandom_range(0, 4) == 0)
                w[22:20] = 3'($urandom_range(4, 7));   // fractional or reserved lmul
            else
                w[22:20] = 3'($urandom_range(0, 3));
        end else if (kind < 96) begin
            if (kind >= 92) begin
                w[6:0] = 7'($urandom());
                if (w[6:0] == OPC_OPV)
                    w[0] = ~w[0];
            end
        end else begin
            w = $urandom();                         // anything at all
        end
        return w;
    endfunction

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        avl         = '0;
        seed_ret    = $urandom(62);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < NUM_INSTR; i++) begin
            gap = $urandom_range(0, 2);
            repeat (gap) begin
                @(posedge clk);
                instr_valid <= 1'b0;
            end
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= random_instr();
            avl         <= ($urandom_range(0, 3) == 0) ? $urandom() : $urandom_range(0, 150);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        $display("outputs checked %0d, control errors %0d, state errors %0d",
                 chk.outputs_checked, chk.ctrl_errors, chk.state_errors);
        if (chk.ctrl_errors == 0 && chk.state_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: stimulus still running after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

// File: tests/rv32v_decode_checker.sv
`timescale 1ns/100ps

module rv32v_decode_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instr_valid,
    input  logic [31:0]                 instr,
    input  logic [31:0]                 avl,
    input  logic                        out_valid,
    input  logic                        illegal,
    input  rv32v_types_pkg::vfu_t       vfu,
    input  rv32v_types_pkg::valuop_t    valuop,
    input  rv32v_types_pkg::vmulop_t    vmulop,
    input  logic                        vmulwiden,
    input  logic                        vmulrethigh,
    input  logic                        vdivremainder,
    input  rv32v_types_pkg::vmaskop_t   vmaskop,
    input  rv32v_types_pkg::vsigntype_t vsigntype,
    input  logic                        vopunsigned,
    input  rv32v_types_pkg::vsew_t      veew_src2,
    input  rv32v_types_pkg::vsew_t      vsew,
    input  logic [31:0]                 vl
);
    import rv32v_types_pkg::*;

    typedef struct packed {
        logic   illegal;
        logic   is_cfg;
        vexec_t exec;
        vsew_t  eew;
    } exp_word_t;

    exp_word_t   exp_q[$];
    exp_word_t   cur;
    exp_word_t   nxt;

    vsew_t       m_sew;         // model vtype state
    logic [31:0] m_vl;
    logic        m_illegal;     // illegal holds between outputs

    int          outputs_checked = 0;
    int          ctrl_errors = 0;
    int          state_errors = 0;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want, input logic is_state);
        if (got !== want) begin
            $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, want);
            if (is_state)
                state_errors++;
            else
                ctrl_errors++;
        end
    endtask

    task automatic opm_model(input logic [5:0] f6, input logic [4:0] vs1, input vsew_t sew,
                             output vexec_t x, output vsew_t eew, output logic ok);
        int         shift;
        logic [2:0] src_w;
        x     = '0;
        eew   = sew;
        ok    = 1'b1;
        shift = 0;
        if (f6 <= 6'd7) begin                       // reductions
            x.vfu = VFU_RED;
            case (f6[2:0])
                3'd1: x.valuop = VALU_AND;
                3'd2: x.valuop = VALU_OR;
                3'd3: x.valuop = VALU_XOR;
                3'd4, 3'd5: x.valuop = VALU_MIN;
                3'd6, 3'd7: x.valuop = VALU_MAX;
                default: x.valuop = VALU_ADD;
            endcase
            x.vopunsigned = f6[2] && !f6[0];
        end else if (f6 <= 6'd11) begin             // averaging add/sub
            x.valuop      = f6[1] ? VALU_SUB : VALU_ADD;
            x.vopunsigned = !f6[0];
        end else if (f6 == 6'd18) begin
            // integer extension where vs1 picks the factor
            x.valuop      = VALU_EXT;
            x.vopunsigned = !vs1[0];
            case (vs1)
                5'd2, 5'd3: shift = 3;
                5'd4, 5'd5: shift = 2;
                5'd6, 5'd7: shift = 1;
                default: ok = 1'b0;
            endcase
            if (int'(sew) < shift)
                ok = 1'b0;
            src_w = sew - 3'(shift);
            eew   = vsew_t'(src_w);
        end else if (f6 >= 6'd24 && f6 <= 6'd31) begin
            x.vfu = VFU_MSK;
            case (f6[2:0])
                3'd0: x.vmaskop = VMSK_NDN;
                3'd2: x.vmaskop = VMSK_OR;
                3'd3: x.vmaskop = VMSK_XOR;
                3'd4, 3'd6: x.vmaskop = VMSK_NOR;
                3'd5: x.vmaskop = VMSK_NND;
                3'd7: x.vmaskop = VMSK_XNR;
                default: x.vmaskop = VMSK_AND;
            endcase
        end else if (f6 >= 6'd32 && f6 <= 6'd35) begin
            x.vfu           = VFU_DIV;
            x.vopunsigned   = !f6[0];
            x.vdivremainder = f6[1];
        end else if (f6 >= 6'd36 && f6 <= 6'd39) begin  // vmulhu vmul vmulhsu vmulh
            x.vfu         = VFU_MUL;
            x.vopunsigned = !f6[0];
            x.vmulrethigh = (f6 != 6'd37);
            if (f6 == 6'd36)
                x.vsigntype = UNSIGNED;
            else if (f6 == 6'd38)
                x.vsigntype = SIGNED_UNSIGNED;
        end else if (f6 == 6'd41 || f6 == 6'd43 || f6 == 6'd45 || f6 == 6'd47) begin
            x.vfu = VFU_MUL;
            case (f6)
                6'd41: x.vmulop = VMUL_MADD;
                6'd43: x.vmulop = VMUL_NMSUB;
                6'd45: x.vmulop = VMUL_MACC;
                default: x.vmulop = VMUL_NMSAC;
            endcase
        end else if (f6 >= 6'd48 && f6 <= 6'd55) begin
            x.valuop      = f6[1] ? VALU_SUB : VALU_ADD;
            x.vopunsigned = !f6[0];
            if (f6[2])
                eew = vsew_t'(sew + 3'd1);          // .w form has an already wide vs2
        end else if (f6 >= 6'd56 && f6 != 6'd57) begin
            x.vfu       = VFU_MUL;
            x.vmulwiden = 1'b1;
            if (f6[2])
                x.vmulop = VMUL_MACC;
            case (f6[2:0])
                3'd0, 3'd4: x.vsigntype = UNSIGNED;
                3'd2, 3'd7: x.vsigntype = SIGNED_UNSIGNED;
                3'd6: x.vsigntype = UNSIGNED_SIGNED;
                default: x.vsigntype = SIGNED;
            endcase
            x.vopunsigned = (x.vsigntype != SIGNED);
        end else begin
            ok = 1'b0;
        end
    endtask

    task automatic opi_model(input logic [5:0] f6, input logic [2:0] f3,
                             output vexec_t x, output logic ok);
        x  = '0;
        ok = 1'b1;
        case (f6)
            6'd0: x.valuop = VALU_ADD;
            6'd2: x.valuop = VALU_SUB;
            6'd3: begin
                x.valuop = VALU_RSUB;
                ok       = (f3 != 3'd0);            // no vector-vector form
            end
            6'd4: begin
                x.valuop      = VALU_MIN;
                x.vopunsigned = 1'b1;
            end
            6'd5: x.valuop = VALU_MIN;
            6'd6: begin
                x.valuop      = VALU_MAX;
                x.vopunsigned = 1'b1;
            end
            6'd7: x.valuop = VALU_MAX;
            6'd9: x.valuop = VALU_AND;
            6'd10: x.valuop = VALU_OR;
            6'd11: x.valuop = VALU_XOR;
            default: ok = 1'b0;
        endcase
    endtask

    task automatic model_decode(input logic [31:0] w, input vsew_t sew, output exp_word_t e);
        logic [2:0] f3;
        logic       ok;
        vexec_t     x;
        vsew_t      eew;
        f3  = w[14:12];
        ok  = 1'b0;
        x   = '0;
        eew = sew;
        e   = '0;
        if (w[6:0] == OPC_OPV) begin
            if (f3 == 3'd7) begin
                if (!w[31]) begin
                    e.is_cfg = 1'b1;
                    x.vfu    = VFU_CFG;
                    ok       = 1'b1;
                end
            end else if (f3 == 3'd2 || f3 == 3'd6) begin
                opm_model(w[31:26], w[19:15], sew, x, eew, ok);
            end else if (f3 == 3'd0 || f3 == 3'd3 || f3 == 3'd4) begin
                opi_model(w[31:26], f3, x, ok);
            end
        end
        e.exec    = x;
        e.eew     = eew;
        e.illegal = !ok;
    endtask

    task automatic apply_vsetvli(input logic [10:0] zimm, input logic [31:0] req);
        int          sew_bits;
        int          lmul_code;
        logic [31:0] vlmax;
        sew_bits  = 8 << zimm[5:3];
        lmul_code = zimm[2:0];
        if (sew_bits > ELEN || lmul_code > 3) begin
            m_vl = '0;                              // vill keeps the old vtype
        end else begin
            vlmax = (VLEN / sew_bits) * (1 << lmul_code);
            m_sew = vsew_t'(zimm[5:3]);
            m_vl  = (req < vlmax) ? req : vlmax;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            m_sew     = SEW8;
            m_vl      = '0;
            m_illegal = 1'b0;
        end else begin
            if (exp_q.size() > 0) begin
                cur = exp_q.pop_front();
                outputs_checked++;
                check_value("out_valid", out_valid, 1'b1, 1'b1);
                check_value("illegal", illegal, cur.illegal, 1'b0);
                m_illegal = cur.illegal;
                if (!cur.illegal) begin
                    check_value("vfu", vfu, cur.exec.vfu, 1'b0);
                    check_value("valuop", valuop, cur.exec.valuop, 1'b0);
                    check_value("vmulop", vmulop, cur.exec.vmulop, 1'b0);
                    check_value("vmulwiden", vmulwiden, cur.exec.vmulwiden, 1'b0);
                    check_value("vmulrethigh", vmulrethigh, cur.exec.vmulrethigh, 1'b0);
                    check_value("vdivremainder", vdivremainder, cur.exec.vdivremainder, 1'b0);
                    check_value("vmaskop", vmaskop, cur.exec.vmaskop, 1'b0);
                    check_value("vsigntype", vsigntype, cur.exec.vsigntype, 1'b0);
                    check_value("vopunsigned", vopunsigned, cur.exec.vopunsigned, 1'b0);
                    if (!cur.is_cfg)
                        check_value("veew_src2", veew_src2, cur.eew, 1'b0);
                end
            end else begin
                check_value("out_valid", out_valid, 1'b0, 1'b1);
                check_value("illegal", illegal, m_illegal, 1'b1);
            end
            check_value("vsew", vsew, m_sew, 1'b1);
            check_value("vl", vl, m_vl, 1'b1);

            // decode with the vtype in force before this edge
            if (instr_valid) begin
                model_decode(instr, m_sew, nxt);
                if (nxt.is_cfg)
                    apply_vsetvli(instr[30:20], avl);
                exp_q.push_back(nxt);
            end
        end
    end

endmodule

// File: src/rv32v_decode_unit.sv
`timescale 1ns/100ps

module rv32v_decode_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instr_valid,
    input  logic [31:0]                 instr,
    input  logic [31:0]                 avl,        // rs1 value for vsetvli
    output logic                        out_valid,
    output logic                        illegal,
    output rv32v_types_pkg::vfu_t       vfu,
    output rv32v_types_pkg::valuop_t    valuop,
    output rv32v_types_pkg::vmulop_t    vmulop,
    output logic                        vmulwiden,
    output logic                        vmulrethigh,
    output logic                        vdivremainder,
    output rv32v_types_pkg::vmaskop_t   vmaskop,
    output rv32v_types_pkg::vsigntype_t vsigntype,
    output logic                        vopunsigned,
    output rv32v_types_pkg::vsew_t      veew_src2,
    output rv32v_types_pkg::vsew_t      vsew,
    output logic [31:0]                 vl
);
    import rv32v_types_pkg::*;

    vopm_t       opm_op;
    vopi_t       opi_op;
    vfunct3_t    vfunct3;
    logic [4:0]  vs1_sel;
    vexec_t      opm_exec;
    logic        opm_valid;
    vsew_t       opm_eew;
    vexec_t      opi_exec;
    logic        opi_valid;
    vsew_t       opi_eew;
    logic        cfg_we;
    logic [10:0] zimm;
    vexec_t      exec;

    vtype_if vtype ();

    rv32v_decode_stage u_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .opm_op      (opm_op),
        .opi_op      (opi_op),
        .vfunct3     (vfunct3),
        .vs1_sel     (vs1_sel),
        .opm_exec    (opm_exec),
        .opm_valid   (opm_valid),
        .opm_eew     (opm_eew),
        .opi_exec    (opi_exec),
        .opi_valid   (opi_valid),
        .opi_eew     (opi_eew),
        .cfg_we      (cfg_we),
        .zimm        (zimm),
        .vtype       (vtype.user),
        .out_valid   (out_valid),
        .illegal     (illegal),
        .exec        (exec),
        .veew_src2   (veew_src2),
        .vsew        (vsew),
        .vl          (vl)
    );

    rv32v_opm_decode u_opm (
        .vopm      (opm_op),
        .vfunct3   (vfunct3),
        .vs1_sel   (vs1_sel),
        .vsew      (vsew),
        .vexec     (opm_exec),
        .valid     (opm_valid),
        .veew_src2 (opm_eew)
    );

    rv32v_opi_decode u_opi (
        .vopi      (opi_op),
        .vfunct3   (vfunct3),
        .vsew      (vsew),
        .vexec     (opi_exec),
        .valid     (opi_valid),
        .veew_src2 (opi_eew)
    );

    rv32v_vtype_csr u_vtype (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfg_we (cfg_we),
        .zimm   (zimm),
        .avl    (avl),
        .vtype  (vtype.csr)
    );

    // control word out as separate fields
    assign vfu           = exec.vfu;
    assign valuop        = exec.valuop;
    assign vmulop        = exec.vmulop;
    assign vmulwiden     = exec.vmulwiden;
    assign vmulrethigh   = exec.vmulrethigh;
    assign vdivremainder = exec.vdivremainder;
    assign vmaskop       = exec.vmaskop;
    assign vsigntype     = exec.vsigntype;
    assign vopunsigned   = exec.vopunsigned;

endmodule

// File: src/rv32v_decode_stage.sv
`timescale 1ns/100ps

module rv32v_decode_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  rv32v_types_pkg::vinstr_u  instr,
    output rv32v_types_pkg::vopm_t    opm_op,
    output rv32v_types_pkg::vopi_t    opi_op,
    output rv32v_types_pkg::vfunct3_t vfunct3,
    output logic [4:0]                vs1_sel,
    input  rv32v_types_pkg::vexec_t   opm_exec,
    input  logic                      opm_valid,
    input  rv32v_types_pkg::vsew_t    opm_eew,
    input  rv32v_types_pkg::vexec_t   opi_exec,
    input  logic                      opi_valid,
    input  rv32v_types_pkg::vsew_t    opi_eew,
    output logic                      cfg_we,
    output logic [10:0]               zimm,
    vtype_if.user                     vtype,
    output logic                      out_valid,
    output logic                      illegal,
    output rv32v_types_pkg::vexec_t   exec,
    output rv32v_types_pkg::vsew_t    veew_src2,
    output rv32v_types_pkg::vsew_t    vsew,
    output logic [31:0]               vl
);
    import rv32v_types_pkg::*;

    logic   is_opv;
    logic   is_cfg;
    logic   claimed;
    vexec_t dec_exec;
    vsew_t  dec_eew;

    assign opm_op  = vopm_t'(instr.arith.funct6);
    assign opi_op  = vopi_t'(instr.arith.funct6);
    assign vfunct3 = instr.arith.funct3;
    assign vs1_sel = instr.arith.vs1;
    assign zimm    = instr.cfg.zimm;

    assign is_opv = (instr.arith.opcode == OPC_OPV);
    assign is_cfg = is_opv && (instr.cfg.funct3 == OPCFG) && !instr.cfg.cfg_bit;
    assign cfg_we = instr_valid && is_cfg;

    // decoder valid sets never overlap
    always_comb begin
        dec_exec = VEXEC_NOP;
        dec_eew  = vtype.vsew;
        claimed  = 1'b0;
        if (is_cfg) begin
            dec_exec.vfu = VFU_CFG;
            claimed      = 1'b1;
        end else if (opm_valid) begin
            dec_exec = opm_exec;
            dec_eew  = opm_eew;
            claimed  = 1'b1;
        end else if (opi_valid) begin
            dec_exec = opi_exec;
            dec_eew  = opi_eew;
            claimed  = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= instr_valid;
            if (instr_valid)
                illegal <= !(is_opv && claimed);
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            exec      <= dec_exec;
            veew_src2 <= dec_eew;
        end
    end

    // already registered in the csr, so a vsetvli shows its new values
    assign vsew = vtype.vsew;
    assign vl   = vtype.vl;

endmodule

// File: src/rv32v_vtype_csr.sv
`timescale 1ns/100ps

module rv32v_vtype_csr (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cfg_we,
    input  logic [10:0] zimm,
    input  logic [31:0] avl,
    vtype_if.csr        vtype
);
    import rv32v_types_pkg::*;

    vsew_t       new_sew;
    vlmul_t      new_lmul;
    logic        cfg_bad;
    logic [31:0] vlmax;

    vsew_t       sew_q;
    vlmul_t      lmul_q;
    logic [31:0] vl_q;
    logic        vill_q;

    always_comb begin
        new_sew  = vsew_t'(zimm[5:3]);
        new_lmul = vlmul_t'(zimm[2:0]);
        cfg_bad  = ((8 << new_sew) > ELEN) || new_lmul[2];  // too wide or fractional
        vlmax    = (VLEN >> (3 + new_sew)) << new_lmul[1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sew_q  <= SEW8;
            lmul_q <= LMUL1;
            vl_q   <= '0;
            vill_q <= 1'b0;
        end else if (cfg_we) begin
            vill_q <= cfg_bad;
            if (cfg_bad) begin
                vl_q <= '0;     // vtype keeps its old value
            end else begin
                sew_q  <= new_sew;
                lmul_q <= new_lmul;
                vl_q   <= (avl < vlmax) ? avl : vlmax;
            end
        end
    end

    assign vtype.vsew  = sew_q;
    assign vtype.vlmul = lmul_q;
    assign vtype.vl    = vl_q;
    assign vtype.vill  = vill_q;

endmodule

// File: decode/rv32v_opi_decode.sv
`timescale 1ns/100ps

module rv32v_opi_decode (
    input  rv32v_types_pkg::vopi_t    vopi,
    input  rv32v_types_pkg::vfunct3_t vfunct3,
    input  rv32v_types_pkg::vsew_t    vsew,
    output rv32v_types_pkg::vexec_t   vexec,
    output logic                      valid,
    output rv32v_types_pkg::vsew_t    veew_src2
);
    import rv32v_types_pkg::*;

    assign veew_src2 = vsew;    // no widening forms on this path

    always_comb begin
        vexec = VEXEC_NOP;      // every op here goes to the alu
        valid = 1'b1;

        case (vopi)
            VADD: vexec.valuop = VALU_ADD;
            VSUB: vexec.valuop = VALU_SUB;
            VRSUB: begin
                vexec.valuop = VALU_RSUB;
                if (vfunct3 == OPIVV)
                    valid = 1'b0;   // reverse sub has only scalar forms
            end
            VAND: vexec.valuop = VALU_AND;
            VOR: vexec.valuop = VALU_OR;
            VXOR: vexec.valuop = VALU_XOR;
            VMINU: begin
                vexec.valuop      = VALU_MIN;
                vexec.vopunsigned = 1'b1;
            end
            VMIN: vexec.valuop = VALU_MIN;
            VMAXU: begin
                vexec.valuop      = VALU_MAX;
                vexec.vopunsigned = 1'b1;
            end
            VMAX: vexec.valuop = VALU_MAX;
            default: valid = 1'b0;
        endcase

        if (!(vfunct3 inside {OPIVV, OPIVX, OPIVI}))
            valid = 1'b0;
    end

endmodule

// File: decode/rv32v_opm_decode.sv
`timescale 1ns/100ps

module rv32v_opm_decode (
    input  rv32v_types_pkg::vopm_t    vopm,
    input  rv32v_types_pkg::vfunct3_t vfunct3,
    input  logic [4:0]                vs1_sel,
    input  rv32v_types_pkg::vsew_t    vsew,
    output rv32v_types_pkg::vexec_t   vexec,
    output logic                      valid,
    output rv32v_types_pkg::vsew_t    veew_src2
);
    import rv32v_types_pkg::*;

    logic [2:0] ext_shift;  // log2 of the extension factor

    always_comb begin
        vexec     = VEXEC_NOP;
        veew_src2 = vsew;
        valid     = 1'b1;
        ext_shift = 3'd0;

        // functional unit select also filters unsupported funct6
        case (vopm)
            VREDSUM, VREDAND, VREDOR, VREDXOR,
            VREDMINU, VREDMIN, VREDMAXU, VREDMAX: vexec.vfu = VFU_RED;
            VMANDN, VMAND, VMOR, VMXOR,
            VMORN, VMNAND, VMNOR, VMXNOR: vexec.vfu = VFU_MSK;
            VDIVU, VDIV, VREMU, VREM: vexec.vfu = VFU_DIV;
            VMULHU, VMUL, VMULHSU, VMULH, VMADD, VNMSUB, VMACC, VNMSAC,
            VWMULU, VWMULSU, VWMUL, VWMACCU, VWMACC, VWMACCUS, VWMACCSU: vexec.vfu = VFU_MUL;
            VAADDU, VAADD, VASUBU, VASUB, VXUNARY0,
            VWADDU, VWADD, VWSUBU, VWSUB, VWADDU_W, VWADD_W, VWSUBU_W, VWSUB_W: vexec.vfu = VFU_ALU;
            default: valid = 1'b0;
        endcase

        case (vopm)
            VREDAND: vexec.valuop = VALU_AND;
            VREDOR: vexec.valuop = VALU_OR;
            VREDXOR: vexec.valuop = VALU_XOR;
            VREDMINU, VREDMIN: vexec.valuop = VALU_MIN;
            VREDMAXU, VREDMAX: vexec.valuop = VALU_MAX;
            VASUBU, VASUB, VWSUBU, VWSUB, VWSUBU_W, VWSUB_W: vexec.valuop = VALU_SUB;
            default: vexec.valuop = VALU_ADD;
        endcase

        case (vopm)
            VREDMINU, VREDMAXU, VAADDU, VASUBU, VDIVU, VREMU,
            VMULHU, VMULHSU, VWADDU, VWSUBU, VWADDU_W, VWSUBU_W,
            VWMULU, VWMULSU, VWMACCU, VWMACCUS, VWMACCSU: vexec.vopunsigned = 1'b1;
            default: vexec.vopunsigned = 1'b0;
        endcase

        case (vopm)
            VMANDN: vexec.vmaskop = VMSK_NDN;
            VMOR: vexec.vmaskop = VMSK_OR;
            VMXOR: vexec.vmaskop = VMSK_XOR;
            VMORN, VMNOR: vexec.vmaskop = VMSK_NOR;
            VMNAND: vexec.vmaskop = VMSK_NND;
            VMXNOR: vexec.vmaskop = VMSK_XNR;
            default: vexec.vmaskop = VMSK_AND;
        endcase

        // multiplier controls
        case (vopm)
            VMULHU, VWMULU, VWMACCU: vexec.vsigntype = UNSIGNED;
            VMULHSU, VWMULSU, VWMACCSU: vexec.vsigntype = SIGNED_UNSIGNED;
            VWMACCUS: vexec.vsigntype = UNSIGNED_SIGNED;
            default: vexec.vsigntype = SIGNED;
        endcase
        case (vopm)
            VMADD: vexec.vmulop = VMUL_MADD;
            VNMSUB: vexec.vmulop = VMUL_NMSUB;
            VMACC, VWMACCU, VWMACC, VWMACCUS, VWMACCSU: vexec.vmulop = VMUL_MACC;
            VNMSAC: vexec.vmulop = VMUL_NMSAC;
            default: vexec.vmulop = UNFUSED;
        endcase
        vexec.vmulrethigh = vopm inside {VMULHU, VMULHSU, VMULH};
        vexec.vmulwiden = vopm inside {VWMULU, VWMULSU, VWMUL, VWMACCU, VWMACC, VWMACCUS, VWMACCSU};
        vexec.vdivremainder = vopm inside {VREMU, VREM};

        if (vopm inside {VWADDU_W, VWADD_W, VWSUBU_W, VWSUB_W})
            veew_src2 = vsew_t'(vsew + 3'd1);   // wide vs2 operand

        // vzext / vsext with odd selectors as the signed forms
        if (vopm == VXUNARY0) begin
            vexec.valuop      = VALU_EXT;
            vexec.vopunsigned = ~vs1_sel[0];
            case (vs1_sel)
                5'd2, 5'd3: ext_shift = 3'd3;   // vf8
                5'd4, 5'd5: ext_shift = 3'd2;   // vf4
                5'd6, 5'd7: ext_shift = 3'd1;   // vf2
                default: valid = 1'b0;
            endcase
            veew_src2 = vsew_t'(vsew - ext_shift);
            if (vsew < ext_shift)
                valid = 1'b0;                   // source below SEW8
        end

        if (vfunct3 != OPMVV && vfunct3 != OPMVX)
            valid = 1'b0;
    end

endmodule

// File: common/vtype_if.sv
`timescale 1ns/100ps

interface vtype_if;
    import rv32v_types_pkg::*;

    vsew_t       vsew;
    vlmul_t      vlmul;
    logic [31:0] vl;
    logic        vill;     // last vsetvli asked for an unsupported config

    modport csr (
        output vsew, vlmul, vl, vill
    );

    modport user (
        input vsew, vlmul, vl, vill
    );

endinterface

// File: common/rv32v_types_pkg.sv
package rv32v_types_pkg;

    localparam int VLEN = 128;           // bits per vector register
    localparam int ELEN = 32;            // widest supported element
    localparam logic [6:0] OPC_OPV = 7'h57;

    typedef enum logic [2:0] {
        SEW8  = 3'd0,
        SEW16 = 3'd1,
        SEW32 = 3'd2,
        SEW64 = 3'd3
    } vsew_t;

    // codes 4..7 are reserved or fractional
    typedef enum logic [2:0] {
        LMUL1     = 3'd0,
        LMUL2     = 3'd1,
        LMUL4     = 3'd2,
        LMUL8     = 3'd3,
        LMUL_RSVD = 3'd4,
        LMUL_F8   = 3'd5,
        LMUL_F4   = 3'd6,
        LMUL_F2   = 3'd7
    } vlmul_t;

    typedef enum logic [2:0] {
        OPIVV = 3'd0,
        OPFVV = 3'd1,
        OPMVV = 3'd2,
        OPIVI = 3'd3,
        OPIVX = 3'd4,
        OPFVF = 3'd5,
        OPMVX = 3'd6,
        OPCFG = 3'd7
    } vfunct3_t;

    typedef enum logic [5:0] {
        VREDSUM  = 6'b000000, VREDAND  = 6'b000001, VREDOR   = 6'b000010,
        VREDXOR  = 6'b000011, VREDMINU = 6'b000100, VREDMIN  = 6'b000101,
        VREDMAXU = 6'b000110, VREDMAX  = 6'b000111, VAADDU   = 6'b001000,
        VAADD    = 6'b001001, VASUBU   = 6'b001010, VASUB    = 6'b001011,
        VXUNARY0 = 6'b010010, VMANDN   = 6'b011000, VMAND    = 6'b011001,
        VMOR     = 6'b011010, VMXOR    = 6'b011011, VMORN    = 6'b011100,
        VMNAND   = 6'b011101, VMNOR    = 6'b011110, VMXNOR   = 6'b011111,
        VDIVU    = 6'b100000, VDIV     = 6'b100001, VREMU    = 6'b100010,
        VREM     = 6'b100011, VMULHU   = 6'b100100, VMUL     = 6'b100101,
        VMULHSU  = 6'b100110, VMULH    = 6'b100111, VMADD    = 6'b101001,
        VNMSUB   = 6'b101011, VMACC    = 6'b101101, VNMSAC   = 6'b101111,
        VWADDU   = 6'b110000, VWADD    = 6'b110001, VWSUBU   = 6'b110010,
        VWSUB    = 6'b110011, VWADDU_W = 6'b110100, VWADD_W  = 6'b110101,
        VWSUBU_W = 6'b110110, VWSUB_W  = 6'b110111, VWMULU   = 6'b111000,
        VWMULSU  = 6'b111010, VWMUL    = 6'b111011, VWMACCU  = 6'b111100,
        VWMACC   = 6'b111101, VWMACCUS = 6'b111110, VWMACCSU = 6'b111111
    } vopm_t;

    typedef enum logic [5:0] {
        VADD  = 6'b000000, VSUB  = 6'b000010, VRSUB = 6'b000011,
        VMINU = 6'b000100, VMIN  = 6'b000101, VMAXU = 6'b000110,
        VMAX  = 6'b000111, VAND  = 6'b001001, VOR   = 6'b001010,
        VXOR  = 6'b001011
    } vopi_t;

    typedef enum logic [2:0] {VFU_ALU, VFU_RED, VFU_MSK, VFU_DIV, VFU_MUL, VFU_CFG} vfu_t;

    // nine ops, so one bit wider than the other selects
    typedef enum logic [3:0] {
        VALU_ADD, VALU_SUB, VALU_RSUB, VALU_AND, VALU_OR,
        VALU_XOR, VALU_MIN, VALU_MAX, VALU_EXT
    } valuop_t;

    typedef enum logic [2:0] {UNFUSED, VMUL_MADD, VMUL_NMSUB, VMUL_MACC, VMUL_NMSAC} vmulop_t;

    typedef enum logic [2:0] {
        VMSK_AND, VMSK_NDN, VMSK_OR, VMSK_XOR, VMSK_NOR, VMSK_NND, VMSK_XNR
    } vmaskop_t;

    typedef enum logic [1:0] {SIGNED, UNSIGNED, SIGNED_UNSIGNED, UNSIGNED_SIGNED} vsigntype_t;

    typedef struct packed {
        vfu_t       vfu;
        valuop_t    valuop;
        vmulop_t    vmulop;
        logic       vmulwiden;
        logic       vmulrethigh;
        logic       vdivremainder;
        vmaskop_t   vmaskop;
        vsigntype_t vsigntype;
        logic       vopunsigned;
    } vexec_t;

    localparam vexec_t VEXEC_NOP = '{
        vfu: VFU_ALU, valuop: VALU_ADD, vmulop: UNFUSED, vmulwiden: 1'b0,
        vmulrethigh: 1'b0, vdivremainder: 1'b0, vmaskop: VMSK_AND,
        vsigntype: SIGNED, vopunsigned: 1'b0
    };

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        vfunct3_t   funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } varith_t;

    typedef struct packed {
        logic        cfg_bit;   // clear for vsetvli
        logic [10:0] zimm;      // [5:3] vsew, [2:0] vlmul
        logic [4:0]  rs1;
        vfunct3_t    funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } vcfg_t;

    typedef union packed {
        varith_t arith;
        vcfg_t   cfg;
    } vinstr_u;

endpackage
